//--- rsm_top.f
source/rsm_pkg.sv
source/alu_shift.sv
source/reg_file.sv
source/datapath.sv
source/instr_decoder.sv
source/control_fsm.sv
source/cpu_core.sv
source/program_ram.sv
source/rsm_top.sv
testbench/rsm_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rsm testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rsm_top.f --top-module rsm_tb -o rsm_sim

result=$(./obj_dir/rsm_sim)
echo "$result"

if echo "$result" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

//--- source/alu_shift.sv
`timescale 1ns/1ps
`default_nettype none

module alu_shift import rsm_pkg::*; (
  input  word_t      a_val,
  input  word_t      b_raw,
  input  word_t      imm5,
  input  logic       sel_a,
  input  logic       sel_b,
  input  logic [1:0] shift,
  input  logic [1:0] alu_op,
  output word_t      result,
  output logic       z,
  output logic       n,
  output logic       v
);

  word_t b_sh;
  word_t op_a;
  word_t op_b;

  always_comb begin
    case (shift)
      SH_LSL:  b_sh = b_raw << 1;
      SH_LSR:  b_sh = b_raw >> 1;
      SH_ASR:  b_sh = $signed(b_raw) >>> 1;
      default: b_sh = b_raw;
    endcase
  end

  // zero for A turns the ALU into a pass-through of B
  assign op_a = sel_a ? '0 : a_val;
  assign op_b = sel_b ? imm5 : b_sh;

  always_comb begin
    v = 1'b0;
    case (alu_op)
      ALU_ADD: begin
        result = op_a + op_b;
        v = (op_a[DATA_W-1] == op_b[DATA_W-1]) && (result[DATA_W-1] != op_a[DATA_W-1]);
      end
      ALU_SUB: begin
        result = op_a - op_b;
        v = (op_a[DATA_W-1] != op_b[DATA_W-1]) && (result[DATA_W-1] != op_a[DATA_W-1]);
      end
      ALU_AND: result = op_a & op_b;
      default: result = ~op_b;
    endcase
  end

  assign z = (result == '0);
  assign n = result[DATA_W-1];

endmodule

`default_nettype wire

//--- source/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm import rsm_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  decode_t    dec,
  output ctrl_t      ctrl,
  output logic [1:0] reg_sel,
  output logic       load_pc,
  output logic       clear_pc,
  output logic       load_ir,
  output logic       load_addr,
  output logic       sel_addr,
  output logic       ram_w_en,
  output logic       halted
);

  typedef enum logic [4:0] {
    st_reset, st_fetch, st_wait, st_load_ir, st_decode,
    st_mov_imm, st_rd_a, st_rd_b, st_mov, st_mvn, st_add, st_and, st_cmp, st_wb_c,
    st_mem_c, st_ld_addr, st_mem_wait, st_ldr_wb, st_str_b, st_str_c, st_str_wr,
    st_halt
  } cpu_state_e;

  cpu_state_e state;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_reset;
    end else begin
      case (state)
        st_reset:   state <= st_fetch;
        st_fetch:   state <= st_wait;
        st_wait:    state <= st_load_ir;
        st_load_ir: state <= st_decode;
        st_decode: begin
          case (dec.opcode)
            OP_MOV:  state <= (dec.op == 2'b10) ? st_mov_imm :
                              (dec.op == 2'b00) ? st_rd_b : st_fetch;
            OP_ALU:  state <= (dec.op == ALU_NOT) ? st_rd_b : st_rd_a;
            OP_LDR:  state <= st_rd_a;
            OP_STR:  state <= st_rd_a;
            OP_HALT: state <= st_halt;
            default: state <= st_fetch;
          endcase
        end
        // memory ops skip the Rm read
        st_rd_a: state <= (dec.opcode == OP_ALU) ? st_rd_b : st_mem_c;
        st_rd_b: begin
          if (dec.opcode == OP_MOV) state <= st_mov;
          else if (dec.op == ALU_SUB) state <= st_cmp;
          else if (dec.op == ALU_AND) state <= st_and;
          else if (dec.op == ALU_NOT) state <= st_mvn;
          else state <= st_add;
        end
        st_mov, st_mvn, st_add, st_and: state <= st_wb_c;
        st_mem_c:    state <= st_ld_addr;
        st_ld_addr:  state <= (dec.opcode == OP_LDR) ? st_mem_wait : st_str_b;
        st_mem_wait: state <= st_ldr_wb;
        st_str_b:    state <= st_str_c;
        st_str_c:    state <= st_str_wr;
        st_halt:     state <= st_halt;
        default:     state <= st_fetch;
      endcase
    end
  end

  always_comb begin
    ctrl           = '0;
    ctrl.w_en      = state inside {st_mov_imm, st_wb_c, st_ldr_wb};
    ctrl.en_a      = (state == st_rd_a);
    ctrl.en_b      = state inside {st_rd_b, st_str_b};
    ctrl.en_c      = state inside {st_mov, st_mvn, st_add, st_and, st_mem_c, st_str_c};
    ctrl.en_status = (state == st_cmp);
    ctrl.sel_a     = state inside {st_mov, st_str_c};
    ctrl.sel_b     = (state == st_mem_c);
    ctrl.wb_sel    = (state == st_mov_imm) ? WB_IMM8 :
                     (state == st_ldr_wb) ? WB_MEM : WB_C;
    ctrl.alu_op    = (state == st_cmp) ? ALU_SUB :
                     (state == st_and) ? ALU_AND :
                     (state == st_mvn) ? ALU_NOT : ALU_ADD;
  end

  assign reg_sel   = state inside {st_rd_a, st_mov_imm} ? SEL_RN :
                     state inside {st_str_b, st_wb_c, st_ldr_wb} ? SEL_RD : SEL_RM;
  assign load_pc   = state inside {st_reset, st_load_ir};
  assign clear_pc  = (state == st_reset);
  assign load_ir   = (state == st_load_ir);
  assign load_addr = (state == st_ld_addr);
  assign sel_addr  = state inside {st_fetch, st_wait, st_load_ir};
  assign ram_w_en  = (state == st_str_wr);
  assign halted    = (state == st_halt);

  // a store only writes right after Rd has been moved into C
  str_write_only: assert property (@(posedge clk) disable iff (!rst_n)
    ram_w_en |-> dec.opcode == OP_STR && $past(ctrl.en_c) && $past(ctrl.sel_a));

  ir_wb_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(load_ir && ctrl.w_en));

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import rsm_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  addr_t start_pc,
  input  word_t ram_r_data,
  output addr_t ram_addr,
  output logic  ram_w_en,
  output word_t ram_w_data,
  output word_t out,
  output logic  halted
);

  addr_t      pc;
  addr_t      next_pc;
  addr_t      data_addr;
  word_t      ir;
  ctrl_t      ctrl;
  decode_t    dec;
  logic [1:0] reg_sel;
  logic       load_pc;
  logic       clear_pc;
  logic       load_ir;
  logic       load_addr;
  logic       sel_addr;

  assign next_pc    = clear_pc ? start_pc : pc + 8'd1;
  assign ram_addr   = sel_addr ? pc : data_addr;
  assign ram_w_data = out;

  always_ff @(posedge clk) begin
    if (load_pc) pc <= next_pc;
    if (load_ir) ir <= ram_r_data;
    // address comes from the low byte of C
    if (load_addr) data_addr <= out[ADDR_W-1:0];
  end

  control_fsm i_control_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec       (dec),
    .ctrl      (ctrl),
    .reg_sel   (reg_sel),
    .load_pc   (load_pc),
    .clear_pc  (clear_pc),
    .load_ir   (load_ir),
    .load_addr (load_addr),
    .sel_addr  (sel_addr),
    .ram_w_en  (ram_w_en),
    .halted    (halted)
  );

  instr_decoder i_instr_decoder (
    .ir      (ir),
    .reg_sel (reg_sel),
    .dec     (dec)
  );

  // status has no reader yet
  datapath i_datapath (
    .clk    (clk),
    .ctrl   (ctrl),
    .dec    (dec),
    .mdata  (ram_r_data),
    .pc     (pc),
    .c_out  (out),
    .status ()
  );

endmodule

`default_nettype wire

//--- source/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import rsm_pkg::*; (
  input  logic       clk,
  input  ctrl_t      ctrl,
  input  decode_t    dec,
  input  word_t      mdata,
  input  addr_t      pc,
  output word_t      c_out,
  output logic [2:0] status
);

  word_t r_data;
  word_t w_data;
  word_t a_reg;
  word_t b_reg;
  word_t c_reg;
  word_t alu_res;
  logic  z;
  logic  n;
  logic  v;

  // writeback mux
  always_comb begin
    case (ctrl.wb_sel)
      WB_PC:   w_data = {{(DATA_W-ADDR_W){1'b0}}, pc};
      WB_IMM8: w_data = dec.sximm8;
      WB_MEM:  w_data = mdata;
      default: w_data = c_reg;
    endcase
  end

  reg_file i_reg_file (
    .clk    (clk),
    .w_en   (ctrl.w_en),
    .w_addr (dec.w_addr),
    .w_data (w_data),
    .r_addr (dec.r_addr),
    .r_data (r_data)
  );

  alu_shift i_alu_shift (
    .a_val  (a_reg),
    .b_raw  (b_reg),
    .imm5   (dec.sximm5),
    .sel_a  (ctrl.sel_a),
    .sel_b  (ctrl.sel_b),
    .shift  (dec.shift),
    .alu_op (ctrl.alu_op),
    .result (alu_res),
    .z      (z),
    .n      (n),
    .v      (v)
  );

  always_ff @(posedge clk) begin
    if (ctrl.en_a) a_reg <= r_data;
    if (ctrl.en_b) b_reg <= r_data;
    if (ctrl.en_c) c_reg <= alu_res;
    if (ctrl.en_status) status <= {z, n, v};
  end

  assign c_out = c_reg;

  // the FSM must pick a writeback source on every register write
  wb_sel_known: assert property (@(posedge clk) ctrl.w_en |-> !$isunknown(ctrl.wb_sel));

endmodule

`default_nettype wire

//--- source/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rsm_pkg::*; (
  input  word_t      ir,
  input  logic [1:0] reg_sel,
  output decode_t    dec
);

  logic [2:0] opcode;
  reg_idx_t   rm;
  reg_idx_t   rd;
  reg_idx_t   rn;
  reg_idx_t   sel_reg;

  assign opcode = ir[OPC_LSB +: 3];
  assign rm     = ir[RM_LSB +: 3];
  assign rd     = ir[RD_LSB +: 3];
  assign rn     = ir[RN_LSB +: 3];

  always_comb begin
    case (reg_sel)
      SEL_RD:  sel_reg = rd;
      SEL_RN:  sel_reg = rn;
      default: sel_reg = rm;
    endcase
  end

  always_comb begin
    dec.opcode = opcode;
    dec.op     = ir[OP_LSB +: 2];
    // shift bits overlap imm5 in LDR/STR
    if (opcode == OP_LDR || opcode == OP_STR) dec.shift = SH_NONE;
    else dec.shift = ir[SH_LSB +: 2];
    dec.sximm5 = {{(DATA_W-5){ir[4]}}, ir[4:0]};
    dec.sximm8 = {{(DATA_W-8){ir[7]}}, ir[7:0]};
    dec.r_addr = sel_reg;
    dec.w_addr = sel_reg;
  end

endmodule

`default_nettype wire

//--- source/program_ram.sv
`timescale 1ns/1ps
`default_nettype none

module program_ram import rsm_pkg::*; (
  input  logic  clk,
  input  logic  w_en,
  input  addr_t addr,
  input  word_t w_data,
  input  logic  host_w_en,
  input  addr_t host_addr,
  input  word_t host_w_data,
  output word_t r_data,
  output word_t host_r_data
);

  word_t mem [RAM_WORDS];

  // host port only active while the core is in reset or halted
  always_ff @(posedge clk) begin
    if (w_en) mem[addr] <= w_data;
    if (host_w_en) mem[host_addr] <= host_w_data;
    r_data      <= mem[addr];
    host_r_data <= mem[host_addr];
  end

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file import rsm_pkg::*; (
  input  logic     clk,
  input  logic     w_en,
  input  reg_idx_t w_addr,
  input  word_t    w_data,
  input  reg_idx_t r_addr,
  output word_t    r_data
);

  word_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (w_en) begin
      regs[w_addr] <= w_data;
    end
  end

  // read is combinational
  assign r_data = regs[r_addr];

endmodule

`default_nettype wire

//--- source/rsm_pkg.sv
`default_nettype none

package rsm_pkg;

  localparam int DATA_W    = 16;
  localparam int ADDR_W    = 8;
  localparam int NUM_REGS  = 8;
  localparam int RAM_WORDS = 256;

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [2:0]        reg_idx_t;

  // major opcodes
  localparam logic [2:0] OP_MOV  = 3'b110;
  localparam logic [2:0] OP_ALU  = 3'b101;
  localparam logic [2:0] OP_LDR  = 3'b011;
  localparam logic [2:0] OP_STR  = 3'b100;
  localparam logic [2:0] OP_HALT = 3'b111;

  localparam logic [1:0] ALU_ADD = 2'b00;
  localparam logic [1:0] ALU_SUB = 2'b01;
  localparam logic [1:0] ALU_AND = 2'b10;
  localparam logic [1:0] ALU_NOT = 2'b11;

  localparam logic [1:0] SH_NONE = 2'b00;
  localparam logic [1:0] SH_LSL  = 2'b01;
  localparam logic [1:0] SH_LSR  = 2'b10;
  localparam logic [1:0] SH_ASR  = 2'b11;

  localparam logic [1:0] SEL_RM = 2'b00;
  localparam logic [1:0] SEL_RD = 2'b01;
  localparam logic [1:0] SEL_RN = 2'b10;

  localparam logic [1:0] WB_C    = 2'b00;
  localparam logic [1:0] WB_PC   = 2'b01;
  localparam logic [1:0] WB_IMM8 = 2'b10;
  localparam logic [1:0] WB_MEM  = 2'b11;

  // lsb of each instruction field
  localparam int OPC_LSB = 13;
  localparam int OP_LSB  = 11;
  localparam int RN_LSB  = 8;
  localparam int RD_LSB  = 5;
  localparam int SH_LSB  = 3;
  localparam int RM_LSB  = 0;

  typedef struct packed {
    logic [2:0] opcode;
    logic [1:0] op;
    logic [1:0] shift;
    word_t      sximm5;
    word_t      sximm8;
    reg_idx_t   r_addr;
    reg_idx_t   w_addr;
  } decode_t;

  typedef struct packed {
    logic       w_en;
    logic       en_a;
    logic       en_b;
    logic       en_c;
    logic       en_status;
    logic       sel_a;
    logic       sel_b;
    logic [1:0] wb_sel;
    logic [1:0] alu_op;
  } ctrl_t;

endpackage

`default_nettype wire

//--- source/rsm_top.sv
`timescale 1ns/1ps
`default_nettype none

module rsm_top import rsm_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  addr_t start_pc,
  input  logic  host_w_en,
  input  addr_t host_addr,
  input  word_t host_w_data,
  output word_t host_r_data,
  output word_t out,
  output logic  halted
);

  addr_t ram_addr;
  logic  ram_w_en;
  word_t ram_w_data;
  word_t ram_r_data;

  cpu_core i_cpu_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_pc   (start_pc),
    .ram_r_data (ram_r_data),
    .ram_addr   (ram_addr),
    .ram_w_en   (ram_w_en),
    .ram_w_data (ram_w_data),
    .out        (out),
    .halted     (halted)
  );

  program_ram i_program_ram (
    .clk         (clk),
    .w_en        (ram_w_en),
    .addr        (ram_addr),
    .w_data      (ram_w_data),
    .host_w_en   (host_w_en),
    .host_addr   (host_addr),
    .host_w_data (host_w_data),
    .r_data      (ram_r_data),
    .host_r_data (host_r_data)
  );

endmodule

`default_nettype wire

//--- testbench/rsm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rsm_tb import rsm_pkg::*; ();

  localparam int CLK_PERIOD = 20;
  localparam int RST_CYCLES = 16;
  // fill 256 plus six tests of roughly 300 to 560 cycles each
  localparam int MAX_CYCLES = 4000;

  logic   clk;
  logic   rst_n;
  addr_t  start_pc;
  logic   host_w_en;
  addr_t  host_addr;
  word_t  host_w_data;
  word_t  host_r_data;
  word_t  out;
  logic   halted;

  // what the RAM is expected to hold before each run
  word_t  image      [RAM_WORDS];
  word_t  model_mem  [RAM_WORDS];
  word_t  model_regs [NUM_REGS];
  word_t  model_c;
  addr_t  wr_ptr;
  int     errors;
  int     checks;
  int     cycle_count;
  integer seed;

  rsm_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_pc    (start_pc),
    .host_w_en   (host_w_en),
    .host_addr   (host_addr),
    .host_w_data (host_w_data),
    .host_r_data (host_r_data),
    .out         (out),
    .halted      (halted)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // instruction encoders
  function automatic word_t enc_mov_imm(input reg_idx_t rn, input logic [7:0] imm8);
    return {OP_MOV, 2'b10, rn, imm8};
  endfunction

  function automatic word_t enc_mov(input reg_idx_t rd, input reg_idx_t rm,
                                    input logic [1:0] sh);
    return {OP_MOV, 2'b00, 3'b000, rd, sh, rm};
  endfunction

  function automatic word_t enc_alu(input logic [1:0] op, input reg_idx_t rd,
                                    input reg_idx_t rn, input reg_idx_t rm,
                                    input logic [1:0] sh);
    return {OP_ALU, op, rn, rd, sh, rm};
  endfunction

  function automatic word_t enc_mem(input logic [2:0] opc, input reg_idx_t rd,
                                    input reg_idx_t rn, input logic [4:0] imm5);
    return {opc, 2'b00, rn, rd, imm5};
  endfunction

  function automatic word_t enc_halt();
    return {OP_HALT, 13'd0};
  endfunction

  function automatic word_t fill_word(input addr_t a);
    return {~a, a} ^ 16'h3c5a;
  endfunction

  function automatic word_t shift_ref(input word_t b, input logic [1:0] sh);
    case (sh)
      2'b01:   return {b[14:0], 1'b0};
      2'b10:   return {1'b0, b[15:1]};
      2'b11:   return {b[15], b[15:1]};
      default: return b;
    endcase
  endfunction

  // instruction-level model, runs from pc0 until HALT
  task automatic run_model(input addr_t pc0);
    addr_t      pc;
    word_t      ir;
    word_t      ea;
    word_t      imm5;
    word_t      imm8;
    reg_idx_t   rn;
    reg_idx_t   rd;
    reg_idx_t   rm;
    logic [1:0] op;
    logic [1:0] sh;
    logic [2:0] opc;
    int         steps;
    logic       done;
    pc = pc0;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 500) begin
      ir = model_mem[pc];
      pc = pc + 8'd1;
      steps++;
      opc = ir[15:13];
      op = ir[12:11];
      rn = ir[10:8];
      rd = ir[7:5];
      sh = ir[4:3];
      rm = ir[2:0];
      imm5 = {{11{ir[4]}}, ir[4:0]};
      imm8 = {{8{ir[7]}}, ir[7:0]};
      case (opc)
        OP_MOV: begin
          if (op == 2'b10) begin
            model_regs[rn] = imm8;
          end else if (op == 2'b00) begin
            model_c = shift_ref(model_regs[rm], sh);
            model_regs[rd] = model_c;
          end
        end
        OP_ALU: begin
          // CMP only touches status
          if (op != ALU_SUB) begin
            case (op)
              ALU_ADD: model_c = model_regs[rn] + shift_ref(model_regs[rm], sh);
              ALU_AND: model_c = model_regs[rn] & shift_ref(model_regs[rm], sh);
              default: model_c = ~shift_ref(model_regs[rm], sh);
            endcase
            model_regs[rd] = model_c;
          end
        end
        OP_LDR: begin
          ea = model_regs[rn] + imm5;
          model_c = ea;
          model_regs[rd] = model_mem[ea[7:0]];
        end
        OP_STR: begin
          ea = model_regs[rn] + imm5;
          model_c = model_regs[rd];
          model_mem[ea[7:0]] = model_regs[rd];
        end
        OP_HALT: done = 1'b1;
        default: ;
      endcase
    end
  endtask

  task automatic hold_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(negedge clk);
  endtask

  task automatic put_word(input addr_t a, input word_t d);
    host_w_en = 1'b1;
    host_addr = a;
    host_w_data = d;
    @(negedge clk);
    host_w_en = 1'b0;
    image[a] = d;
  endtask

  task automatic emit(input word_t instr);
    put_word(wr_ptr, instr);
    wr_ptr = wr_ptr + 8'd1;
  endtask

  task automatic read_back(input string name);
    for (int i = 0; i < RAM_WORDS; i++) begin
      host_addr = addr_t'(i);
      @(negedge clk);
      checks++;
      if (host_r_data !== model_mem[i]) begin
        $display("MISMATCH at %0t: %s mem[%02h] got %04h expected %04h",
                 $time, name, i, host_r_data, model_mem[i]);
        errors++;
      end
    end
  endtask

  task automatic run_and_check(input string name, input addr_t pc0, input int limit,
                               input int hold);
    int n;
    for (int i = 0; i < RAM_WORDS; i++) model_mem[i] = image[i];
    run_model(pc0);
    start_pc = pc0;
    @(negedge clk);
    rst_n = 1'b1;
    n = 0;
    while (!halted && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (!halted) begin
      $display("%s: core did not reach HALT within %0d cycles", name, limit);
      errors++;
    end else begin
      // out must hold the last C while nothing else happens
      repeat (hold) begin
        checks++;
        if (out !== model_c) begin
          $display("MISMATCH at %0t: %s out got %04h expected %04h",
                   $time, name, out, model_c);
          errors++;
        end
        if (halted !== 1'b1) begin
          $display("%s: halted dropped after HALT at %0t", name, $time);
          errors++;
        end
        @(negedge clk);
      end
      read_back(name);
    end
    for (int i = 0; i < RAM_WORDS; i++) image[i] = model_mem[i];
  endtask

  task automatic test_mov_imm_store();
    hold_reset();
    wr_ptr = 8'h00;
    emit(enc_mov_imm(3'd0, 8'h40));
    emit(enc_mov_imm(3'd1, 8'h5a));
    emit(enc_mov_imm(3'd2, 8'hfd));
    emit(enc_mem(OP_STR, 3'd1, 3'd0, 5'd0));
    emit(enc_mem(OP_STR, 3'd2, 3'd0, 5'd1));
    emit(enc_mov_imm(3'd3, 8'h80));
    emit(enc_mem(OP_STR, 3'd3, 3'd0, 5'd2));
    emit(enc_halt());
    run_and_check("mov_imm_store", 8'h00, 120, 2);
  endtask

  task automatic test_alu_shifts();
    logic [1:0] sh;
    hold_reset();
    wr_ptr = 8'h00;
    emit(enc_mov_imm(3'd0, 8'h50));
    emit(enc_mov_imm(3'd1, 8'h93));
    emit(enc_mov_imm(3'd2, 8'h35));
    for (int k = 0; k < 4; k++) begin
      sh = k[1:0];
      emit(enc_alu(ALU_ADD, 3'd3, 3'd2, 3'd1, sh));
      emit(enc_alu(ALU_AND, 3'd4, 3'd2, 3'd1, sh));
      emit(enc_alu(ALU_NOT, 3'd5, 3'd2, 3'd1, sh));
      emit(enc_mem(OP_STR, 3'd3, 3'd0, 5'(3*k)));
      emit(enc_mem(OP_STR, 3'd4, 3'd0, 5'(3*k+1)));
      emit(enc_mem(OP_STR, 3'd5, 3'd0, 5'(3*k+2)));
    end
    emit(enc_mov(3'd6, 3'd1, SH_ASR));
    emit(enc_mem(OP_STR, 3'd6, 3'd0, 5'd12));
    emit(enc_halt());
    run_and_check("alu_shifts", 8'h00, 400, 2);
  endtask

  task automatic test_load_store_copy();
    hold_reset();
    put_word(8'h47, 16'hbeef);
    put_word(8'h4a, 16'h1234);
    wr_ptr = 8'h00;
    emit(enc_mov_imm(3'd0, 8'h48));
    emit(enc_mem(OP_LDR, 3'd1, 3'd0, 5'd2));
    // negative offsets -1, -4 and -16
    emit(enc_mem(OP_LDR, 3'd2, 3'd0, 5'h1f));
    emit(enc_mov_imm(3'd3, 8'h58));
    emit(enc_mem(OP_STR, 3'd1, 3'd3, 5'h1c));
    emit(enc_mem(OP_STR, 3'd2, 3'd3, 5'd5));
    emit(enc_mem(OP_LDR, 3'd4, 3'd3, 5'h10));
    emit(enc_mem(OP_STR, 3'd4, 3'd0, 5'd15));
    emit(enc_halt());
    run_and_check("load_store_copy", 8'h00, 200, 2);
  endtask

  task automatic test_start_pc();
    hold_reset();
    // decoy at address 0 that must not run
    wr_ptr = 8'h00;
    emit(enc_mov_imm(3'd0, 8'h5e));
    emit(enc_mov_imm(3'd1, 8'h11));
    emit(enc_mem(OP_STR, 3'd1, 3'd0, 5'd0));
    emit(enc_halt());
    wr_ptr = 8'h20;
    emit(enc_mov_imm(3'd0, 8'h5e));
    emit(enc_mov_imm(3'd1, 8'h22));
    emit(enc_mem(OP_STR, 3'd1, 3'd0, 5'd1));
    emit(enc_halt());
    run_and_check("start_pc", 8'h20, 120, 2);
  endtask

  task automatic test_random_program();
    logic [31:0] rnd;
    logic [2:0]  kind;
    reg_idx_t    rd;
    reg_idx_t    rn;
    reg_idx_t    rm;
    logic [1:0]  sh;
    hold_reset();
    wr_ptr = 8'h00;
    // r0 stays the store base
    emit(enc_mov_imm(3'd0, 8'h44));
    for (int r = 1; r < NUM_REGS; r++) begin
      rnd = $random(seed);
      emit(enc_mov_imm(reg_idx_t'(r), rnd[7:0]));
    end
    for (int i = 0; i < 14; i++) begin
      rnd = $random(seed);
      rd = 3'd1 + (rnd[10:8] % 3'd7);
      rn = rnd[13:11];
      rm = rnd[16:14];
      sh = rnd[18:17];
      kind = 3'(rnd[31:19] % 13'd5);
      case (kind)
        3'd0:    emit(enc_mov(rd, rm, sh));
        3'd1:    emit(enc_alu(ALU_ADD, rd, rn, rm, sh));
        3'd2:    emit(enc_alu(ALU_AND, rd, rn, rm, sh));
        3'd3:    emit(enc_alu(ALU_NOT, rd, rn, rm, sh));
        default: emit(enc_mem(OP_STR, rnd[10:8], 3'd0, {1'b0, rnd[3:0]}));
      endcase
    end
    emit(enc_mem(OP_STR, 3'd7, 3'd0, 5'd14));
    emit(enc_mem(OP_STR, 3'd3, 3'd0, 5'd15));
    emit(enc_halt());
    run_and_check("random_program", 8'h00, 400, 2);
  endtask

  task automatic test_halt_hold();
    hold_reset();
    wr_ptr = 8'h00;
    emit(enc_mov_imm(3'd0, 8'h58));
    emit(enc_mov_imm(3'd1, 8'h12));
    emit(enc_mov_imm(3'd2, 8'hb4));
    emit(enc_alu(ALU_ADD, 3'd3, 3'd1, 3'd2, SH_LSL));
    emit(enc_mem(OP_STR, 3'd3, 3'd0, 5'd0));
    emit(enc_alu(ALU_SUB, 3'd0, 3'd1, 3'd2, SH_NONE));
    emit(enc_halt());
    // store past HALT must never happen
    emit(enc_mem(OP_STR, 3'd1, 3'd0, 5'd1));
    run_and_check("halt_hold", 8'h00, 200, 24);
  endtask

  initial begin
    rst_n = 1'b0;
    start_pc = '0;
    host_w_en = 1'b0;
    host_addr = '0;
    host_w_data = '0;
    seed = 32'hafee;
    errors = 0;
    checks = 0;
    wr_ptr = '0;
    model_c = '0;
    for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
    hold_reset();
    for (int i = 0; i < RAM_WORDS; i++) put_word(addr_t'(i), fill_word(addr_t'(i)));
    test_mov_imm_store();
    test_alu_shifts();
    test_load_store_copy();
    test_start_pc();
    test_random_program();
    test_halt_hold();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
